//--- tb.f
logic/ExecPkg.sv
logic/Multiply.sv
logic/Divide.sv
logic/ResultArbiter.sv
logic/MulDivUnit.sv
verif/MulDivChecker.sv
verif/MulDivTb.sv

//--- Bender.yml
package:
  name: muldiv_unit

sources:
  - files:
      - logic/ExecPkg.sv
      - logic/Multiply.sv
      - logic/Divide.sv
      - logic/ResultArbiter.sv
      - logic/MulDivUnit.sv
  - target: test
    files:
      - verif/MulDivChecker.sv
      - verif/MulDivTb.sv

//--- verif/MulDivTb.sv
`timescale 1ns/1ps
`default_nettype none

module MulDivTb;
    import ExecPkg::*;

    localparam int MUL_ISSUES = 60;
    localparam int DIV_ISSUES = 16;
    localparam int MIX_ISSUES = 80;
    localparam int BR_ISSUES  = 80;
    localparam int WATCHDOG   = (MUL_ISSUES + DIV_ISSUES + MIX_ISSUES + BR_ISSUES) * 40 + 200;
    localparam int DRAIN_MAX  = 300;    // a full divide plus a long wait for the bus.
    localparam logic [XLEN-1:0] MIN_INT = {1'b1, {(XLEN-1){1'b0}}};

    logic             clk;
    logic             rst;
    logic             issueValid;
    MulDivOp          issueOp;
    logic [XLEN-1:0]  issueSrcA;
    logic [XLEN-1:0]  issueSrcB;
    logic [TAG_W-1:0] issueTag;
    logic [SQN_W-1:0] issueSqN;
    logic             branchTaken;
    logic [SQN_W-1:0] branchSqN;
    logic             divBusy;
    logic             resultValid;
    logic [TAG_W-1:0] resultTag;
    logic [SQN_W-1:0] resultSqN;
    logic [XLEN-1:0]  result;
    logic             testEnd;
    int               testId;
    int               errorCount;
    int               pending;

    integer           seed;
    logic [SQN_W-1:0] nextSqN;
    logic             lastDiv;          // divBusy does not show last cycle's divide yet.

    MulDivUnit MulDivUnit_inst (.*);
    MulDivChecker MulDivChecker_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog expired, the run did not finish within %0d cycles", WATCHDOG);
        $display("Errors found");
        $finish;
    end

    function automatic logic [XLEN-1:0] pickOperand();
        case ($random(seed) & 7)
            0: return '0;
            1: return '1;
            2: return MIN_INT;
            default: return $random(seed);
        endcase
    endfunction

    // kind 0 gives multiplies, 1 divides, 2 a mix with one divide in four.
    function automatic MulDivOp pickOp(input int kind);
        logic [2:0] code;
        code = 3'($random(seed));
        if (kind != 2) begin
            code[2] = kind == 1;
        end else begin
            code[2] = code[2] && (($random(seed) & 1) == 0);
        end
        return MulDivOp'(code);
    endfunction

    task automatic idleCycle();
        @(posedge clk);
        issueValid  <= 1'b0;
        branchTaken <= 1'b0;
        lastDiv      = 1'b0;
    endtask

    task automatic branchAt(input logic [SQN_W-1:0] sqN);
        @(posedge clk);
        issueValid  <= 1'b0;
        branchTaken <= 1'b1;
        branchSqN   <= sqN;
        nextSqN      = sqN + 1'b1;
        lastDiv      = 1'b0;
    endtask

    // a divide only goes out while the divider is free, else the slot stays idle.
    task automatic tryIssue(input MulDivOp op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b, output bit ok);
        bit isDiv;
        isDiv = op inside {DIV, DIVU, REM, REMU};
        @(posedge clk);
        ok           = !(isDiv && (divBusy || lastDiv));
        issueValid  <= ok;
        branchTaken <= 1'b0;
        if (ok) begin
            issueOp   <= op;
            issueSrcA <= a;
            issueSrcB <= b;
            issueTag  <= TAG_W'($random(seed));
            issueSqN  <= nextSqN;
            nextSqN    = nextSqN + 1'b1;
        end
        lastDiv = ok && isDiv;
    endtask

    task automatic runPhase(input int kind, input int count, input bit withBranch);
        int done;
        bit ok;
        done = 0;
        while (done < count) begin
            if (withBranch && done >= 4 && ($random(seed) & 7) == 0) begin
                branchAt(nextSqN - 1'b1 - SQN_W'($random(seed) & 3));
            end
            tryIssue(pickOp(kind), pickOperand(), pickOperand(), ok);
            done += ok;
            if (($random(seed) & 3) == 0) begin
                idleCycle();
            end
        end
    endtask

    task automatic runDivides();
        MulDivOp         op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        bit              ok;
        for (int i = 0; i < DIV_ISSUES; i++) begin
            op = pickOp(1);
            a  = pickOperand();
            b  = pickOperand();
            if (i < 4) begin            // overflow first, then divide by zero.
                op = (i % 2 == 1) ? REM : DIV;
                a  = (i < 2) ? MIN_INT : a;
                b  = (i < 2) ? '1 : '0;
            end
            ok = 1'b0;
            while (!ok) begin
                tryIssue(op, a, b, ok);
            end
        end
    endtask

    task automatic finishTest(input int id);
        int waited;
        waited = 0;
        idleCycle();
        while (pending != 0 && waited < DRAIN_MAX) begin
            idleCycle();
            waited++;
        end
        @(posedge clk);
        testEnd <= 1'b1;
        testId  <= id;
        @(posedge clk);
        testEnd <= 1'b0;
    endtask

    initial begin
        seed        = 32'hdbb3_dff0;
        rst         = 1'b1;
        issueValid  = 1'b0;
        issueOp     = MUL;
        issueSrcA   = '0;
        issueSrcB   = '0;
        issueTag    = '0;
        issueSqN    = '0;
        branchTaken = 1'b0;
        branchSqN   = '0;
        testEnd     = 1'b0;
        testId      = 0;
        nextSqN     = '0;
        lastDiv     = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (4) idleCycle();
        finishTest(0);
        runPhase(0, MUL_ISSUES, 1'b0);
        finishTest(1);
        runDivides();
        finishTest(2);
        runPhase(2, MIX_ISSUES, 1'b0);
        finishTest(3);
        runPhase(2, BR_ISSUES, 1'b1);
        finishTest(4);
        repeat (2) @(posedge clk);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/MulDivChecker.sv
`timescale 1ns/1ps
`default_nettype none

module MulDivChecker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issueValid,
    input  ExecPkg::MulDivOp            issueOp,
    input  logic [ExecPkg::XLEN-1:0]    issueSrcA,
    input  logic [ExecPkg::XLEN-1:0]    issueSrcB,
    input  logic [ExecPkg::TAG_W-1:0]   issueTag,
    input  logic [ExecPkg::SQN_W-1:0]   issueSqN,
    input  logic                        branchTaken,
    input  logic [ExecPkg::SQN_W-1:0]   branchSqN,
    input  logic                        divBusy,
    input  logic                        resultValid,
    input  logic [ExecPkg::TAG_W-1:0]   resultTag,
    input  logic [ExecPkg::SQN_W-1:0]   resultSqN,
    input  logic [ExecPkg::XLEN-1:0]    result,
    input  logic                        testEnd,
    input  int                          testId,
    output int                          errorCount,
    output int                          pending
);
    import ExecPkg::*;

    localparam int ENTRIES   = 2 ** SQN_W;
    localparam int LAST_TEST = 4;
    localparam logic [XLEN-1:0] MIN_INT = {1'b1, {(XLEN-1){1'b0}}};

    logic             live     [ENTRIES];     // model entries keyed by sqN.
    logic             isMul    [ENTRIES];
    logic [TAG_W-1:0] expTag   [ENTRIES];
    logic [XLEN-1:0]  expValue [ENTRIES];
    int               issuedAt [ENTRIES];
    int               cycle;
    int               checks;
    int               testChecks;
    int               testErrors;
    logic             seenIssue;

    initial begin
        errorCount = 0;
        pending    = 0;
        cycle      = 0;
        checks     = 0;
        testChecks = 0;
        testErrors = 0;
        seenIssue  = 1'b0;
        for (int i = 0; i < ENTRIES; i++) begin
            live[i] = 1'b0;
        end
    end

    // RV32M results, including divide by zero and signed overflow.
    function automatic logic [XLEN-1:0] modelResult(input MulDivOp op,
                                                    input logic [XLEN-1:0] a,
                                                    input logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic [2*XLEN-1:0]      prod;
        sa = a;
        sb = b;
        case (op)
            MULH:    prod = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{b[XLEN-1]}}, b};
            MULSU:   prod = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{1'b0}}, b};
            default: prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        endcase
        if (op == MUL) return prod[XLEN-1:0];
        if (op inside {MULH, MULSU, MULU}) return prod[2*XLEN-1:XLEN];
        if (b == '0) return (op inside {DIV, DIVU}) ? '1 : a;
        if (op inside {DIV, REM} && a == MIN_INT && b == '1) return (op == DIV) ? MIN_INT : '0;
        case (op)
            DIV:     return sa / sb;
            REM:     return sa % sb;
            DIVU:    return a / b;
            default: return a % b;
        endcase
    endfunction

    function automatic logic isYounger(input logic [SQN_W-1:0] sqN,
                                       input logic [SQN_W-1:0] brSqN);
        logic [SQN_W-1:0] diff;
        diff = sqN - brSqN;
        return diff != '0 && !diff[SQN_W-1];
    endfunction

    task automatic flagError();
        errorCount++;
        testErrors++;
    endtask

    task automatic checkResult();
        int idx;
        idx = resultSqN;
        checks++;
        testChecks++;
        if (!live[idx]) begin
            $display("result with sqN %0d appeared but no such micro-op is in flight", idx);
            flagError();
            return;
        end
        if (resultTag !== expTag[idx]) begin
            $display("[ERROR] resultTag sqN 0x%02h: got 0x%02h, expected 0x%02h",
                     idx, resultTag, expTag[idx]);
            flagError();
        end
        if (result !== expValue[idx]) begin
            $display("[ERROR] result sqN 0x%02h: got 0x%08h, expected 0x%08h",
                     idx, result, expValue[idx]);
            flagError();
        end
        if (isMul[idx] && cycle - issuedAt[idx] != MUL_LATENCY) begin
            $display("[ERROR] resultValid latency sqN 0x%02h: got 0x%0h, expected 0x%0h",
                     idx, cycle - issuedAt[idx], MUL_LATENCY);
            flagError();
        end
        live[idx] = 1'b0;
        pending--;
    endtask

    task automatic recordIssue();
        int idx;
        idx = issueSqN;
        if (live[idx]) begin
            $display("sqN %0d was issued again while still in flight", idx);
            flagError();
        end else begin
            pending++;
        end
        live[idx]     = 1'b1;
        isMul[idx]    = issueOp inside {MUL, MULH, MULSU, MULU};
        expTag[idx]   = issueTag;
        expValue[idx] = modelResult(issueOp, issueSrcA, issueSrcB);
        issuedAt[idx] = cycle;
        seenIssue     = 1'b1;
    endtask

    task automatic closeTest();
        string name;
        case (testId)
            0: name = "reset";
            1: name = "multiply";
            2: name = "divide";
            3: name = "shared bus";
            default: name = "branch kill";
        endcase
        if (pending != 0) begin
            $display("%0d results never appeared on the result bus", pending);
            flagError();
            for (int i = 0; i < ENTRIES; i++) begin
                live[i] = 1'b0;
            end
            pending = 0;
        end
        $display("test %s: %0d checks, %0d errors", name, testChecks, testErrors);
        if (testId == LAST_TEST) begin
            $display("total: %0d checks, %0d errors", checks, errorCount);
        end
        testChecks = 0;
        testErrors = 0;
    endtask

    // sampled mid-cycle, the output is checked before a branch prunes the model.
    always @(negedge clk) begin
        cycle++;
        if ((rst || !seenIssue) && (resultValid === 1'b1 || divBusy === 1'b1)) begin
            $display("result bus or divider busy active during reset or before the first issue");
            flagError();
        end
        if (!rst) begin
            if (resultValid) begin
                checkResult();
            end
            if (issueValid) begin
                recordIssue();
            end
            if (branchTaken) begin
                for (int i = 0; i < ENTRIES; i++) begin
                    if (live[i] && isYounger(SQN_W'(i), branchSqN)) begin
                        live[i] = 1'b0;
                        pending--;
                    end
                end
            end
            if (testEnd) begin
                closeTest();
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/MulDivUnit.sv
`timescale 1ns/1ps
`default_nettype none

module MulDivUnit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issueValid,
    input  ExecPkg::MulDivOp            issueOp,
    input  logic [ExecPkg::XLEN-1:0]    issueSrcA,
    input  logic [ExecPkg::XLEN-1:0]    issueSrcB,
    input  logic [ExecPkg::TAG_W-1:0]   issueTag,
    input  logic [ExecPkg::SQN_W-1:0]   issueSqN,
    input  logic                        branchTaken,
    input  logic [ExecPkg::SQN_W-1:0]   branchSqN,
    output logic                        divBusy,
    output logic                        resultValid,
    output logic [ExecPkg::TAG_W-1:0]   resultTag,
    output logic [ExecPkg::SQN_W-1:0]   resultSqN,
    output logic [ExecPkg::XLEN-1:0]    result
);
    import ExecPkg::*;

    logic               mulValid;
    logic [TAG_W-1:0]   mulTag;
    logic [SQN_W-1:0]   mulSqN;
    logic [XLEN-1:0]    mulResult;

    logic               divValid;
    logic [TAG_W-1:0]   divTag;
    logic [SQN_W-1:0]   divSqN;
    logic [XLEN-1:0]    divResult;
    logic               divGrant;

    // both units see every issue and pick their own opcodes.
    Multiply Multiply_inst (
        .clk         (clk),
        .rst         (rst),
        .issueValid  (issueValid),
        .issueOp     (issueOp),
        .issueSrcA   (issueSrcA),
        .issueSrcB   (issueSrcB),
        .issueTag    (issueTag),
        .issueSqN    (issueSqN),
        .branchTaken (branchTaken),
        .branchSqN   (branchSqN),
        .mulValid    (mulValid),
        .mulTag      (mulTag),
        .mulSqN      (mulSqN),
        .mulResult   (mulResult)
    );

    Divide Divide_inst (
        .clk         (clk),
        .rst         (rst),
        .issueValid  (issueValid),
        .issueOp     (issueOp),
        .issueSrcA   (issueSrcA),
        .issueSrcB   (issueSrcB),
        .issueTag    (issueTag),
        .issueSqN    (issueSqN),
        .branchTaken (branchTaken),
        .branchSqN   (branchSqN),
        .divBusy     (divBusy),
        .divValid    (divValid),
        .divTag      (divTag),
        .divSqN      (divSqN),
        .divResult   (divResult),
        .divGrant    (divGrant)
    );

    ResultArbiter ResultArbiter_inst (
        .clk         (clk),
        .rst         (rst),
        .mulValid    (mulValid),
        .mulTag      (mulTag),
        .mulSqN      (mulSqN),
        .mulResult   (mulResult),
        .divValid    (divValid),
        .divTag      (divTag),
        .divSqN      (divSqN),
        .divResult   (divResult),
        .divGrant    (divGrant),
        .branchTaken (branchTaken),
        .branchSqN   (branchSqN),
        .resultValid (resultValid),
        .resultTag   (resultTag),
        .resultSqN   (resultSqN),
        .result      (result)
    );

endmodule

`default_nettype wire

//--- logic/ResultArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ResultArbiter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        mulValid,
    input  logic [ExecPkg::TAG_W-1:0]   mulTag,
    input  logic [ExecPkg::SQN_W-1:0]   mulSqN,
    input  logic [ExecPkg::XLEN-1:0]    mulResult,
    input  logic                        divValid,
    input  logic [ExecPkg::TAG_W-1:0]   divTag,
    input  logic [ExecPkg::SQN_W-1:0]   divSqN,
    input  logic [ExecPkg::XLEN-1:0]    divResult,
    output logic                        divGrant,
    input  logic                        branchTaken,
    input  logic [ExecPkg::SQN_W-1:0]   branchSqN,
    output logic                        resultValid,
    output logic [ExecPkg::TAG_W-1:0]   resultTag,
    output logic [ExecPkg::SQN_W-1:0]   resultSqN,
    output logic [ExecPkg::XLEN-1:0]    result
);
    import ExecPkg::*;

    logic mulTake;
    logic divKill;

    // the multiplier cannot stall, so it always wins the bus.
    assign mulTake  = mulValid && !isKilled(branchTaken, branchSqN, mulSqN);
    assign divKill  = isKilled(branchTaken, branchSqN, divSqN);
    assign divGrant = divValid && !mulValid && !divKill;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= mulTake || divGrant;
        end
    end

    always_ff @(posedge clk) begin
        if (mulValid) begin
            resultTag <= mulTag;
            resultSqN <= mulSqN;
            result    <= mulResult;
        end else begin
            resultTag <= divTag;        // held by the divider until granted.
            resultSqN <= divSqN;
            result    <= divResult;
        end
    end

endmodule

`default_nettype wire

//--- logic/Divide.sv
`timescale 1ns/1ps
`default_nettype none

module Divide (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issueValid,
    input  ExecPkg::MulDivOp            issueOp,
    input  logic [ExecPkg::XLEN-1:0]    issueSrcA,
    input  logic [ExecPkg::XLEN-1:0]    issueSrcB,
    input  logic [ExecPkg::TAG_W-1:0]   issueTag,
    input  logic [ExecPkg::SQN_W-1:0]   issueSqN,
    input  logic                        branchTaken,
    input  logic [ExecPkg::SQN_W-1:0]   branchSqN,
    output logic                        divBusy,
    output logic                        divValid,
    output logic [ExecPkg::TAG_W-1:0]   divTag,
    output logic [ExecPkg::SQN_W-1:0]   divSqN,
    output logic [ExecPkg::XLEN-1:0]    divResult,
    input  logic                        divGrant
);
    import ExecPkg::*;

    localparam logic [XLEN-1:0] MIN_INT = {1'b1, {(XLEN-1){1'b0}}};

    DivState            state;
    logic [DIV_CNT_W-1:0] count;

    logic [XLEN-1:0]    quot;       // dividend bits shift out, quotient bits shift in.
    logic [XLEN-1:0]    rem;
    logic [XLEN-1:0]    divisor;
    logic [XLEN-1:0]    dividend;
    logic               isRem;
    logic               negQ;
    logic               negR;
    logic               divZero;
    logic               overflow;

    logic               isDivOp;
    logic               signedOp;
    logic               load;
    logic               step;
    logic               fix;
    logic               holdKill;
    logic [XLEN:0]      trial;
    logic [XLEN-1:0]    qFinal;
    logic [XLEN-1:0]    rFinal;

    assign isDivOp  = issueOp inside {DIV, DIVU, REM, REMU};
    assign signedOp = issueOp inside {DIV, REM};
    assign holdKill = isKilled(branchTaken, branchSqN, divSqN);

    assign load = (state == IDLE) && issueValid && isDivOp &&
                  !isKilled(branchTaken, branchSqN, issueSqN);
    assign step = (state == RUN) && (count != DIV_CNT_W'(XLEN));
    assign fix  = (state == RUN) && (count == DIV_CNT_W'(XLEN));

    // restoring step, negative trial keeps the shifted remainder.
    assign trial = {rem, quot[XLEN-1]} - {1'b0, divisor};

    always_comb begin
        if (divZero) begin
            qFinal = '1;
            rFinal = dividend;
        end else if (overflow) begin
            qFinal = MIN_INT;
            rFinal = '0;
        end else begin
            qFinal = negQ ? -quot : quot;
            rFinal = negR ? -rem : rem;
        end
    end

    assign divBusy  = state != IDLE;
    assign divValid = state == DONE;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            count <= '0;
        end else if (state != IDLE && holdKill) begin
            state <= IDLE;                  // younger than the branch.
        end else begin
            case (state)
                IDLE: begin
                    if (load) begin
                        state <= RUN;
                        count <= '0;
                    end
                end
                RUN: begin
                    count <= count + 1'b1;
                    if (fix) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    if (divGrant) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            divTag   <= issueTag;
            divSqN   <= issueSqN;
            dividend <= issueSrcA;
            quot     <= (signedOp && issueSrcA[XLEN-1]) ? -issueSrcA : issueSrcA;
            divisor  <= (signedOp && issueSrcB[XLEN-1]) ? -issueSrcB : issueSrcB;
            rem      <= '0;
            isRem    <= issueOp inside {REM, REMU};
            negQ     <= signedOp && (issueSrcA[XLEN-1] ^ issueSrcB[XLEN-1]);
            negR     <= signedOp && issueSrcA[XLEN-1];
            divZero  <= issueSrcB == '0;
            overflow <= signedOp && (issueSrcA == MIN_INT) && (issueSrcB == '1);
        end else if (step) begin
            quot <= {quot[XLEN-2:0], !trial[XLEN]};
            rem  <= trial[XLEN] ? {rem[XLEN-2:0], quot[XLEN-1]} : trial[XLEN-1:0];
        end else if (fix) begin
            divResult <= isRem ? rFinal : qFinal;
        end
    end

endmodule

`default_nettype wire

//--- logic/Multiply.sv
`timescale 1ns/1ps
`default_nettype none

module Multiply (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issueValid,
    input  ExecPkg::MulDivOp            issueOp,
    input  logic [ExecPkg::XLEN-1:0]    issueSrcA,
    input  logic [ExecPkg::XLEN-1:0]    issueSrcB,
    input  logic [ExecPkg::TAG_W-1:0]   issueTag,
    input  logic [ExecPkg::SQN_W-1:0]   issueSqN,
    input  logic                        branchTaken,
    input  logic [ExecPkg::SQN_W-1:0]   branchSqN,
    output logic                        mulValid,
    output logic [ExecPkg::TAG_W-1:0]   mulTag,
    output logic [ExecPkg::SQN_W-1:0]   mulSqN,
    output logic [ExecPkg::XLEN-1:0]    mulResult
);
    import ExecPkg::*;

    // index 0 is the entry register and stAcc[i] holds the sum after stage i.
    logic              stValid  [0:MUL_STAGES];
    logic [XLEN-1:0]   stA      [0:MUL_STAGES-1];
    logic [XLEN-1:0]   stB      [0:MUL_STAGES-1];
    logic [PROD_W-1:0] stAcc    [1:MUL_STAGES];
    logic              stInvert [0:MUL_STAGES];
    logic              stHigh   [0:MUL_STAGES];
    logic [TAG_W-1:0]  stTag    [0:MUL_STAGES];
    logic [SQN_W-1:0]  stSqN    [0:MUL_STAGES];

    logic isMulOp;
    logic lowZero;

    assign isMulOp = issueOp inside {MUL, MULH, MULSU, MULU};
    assign lowZero = stAcc[MUL_STAGES][XLEN-1:0] == '0; // carry into negated high half.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i <= MUL_STAGES; i++) begin
                stValid[i] <= 1'b0;
            end
            mulValid <= 1'b0;
        end else begin
            stValid[0] <= issueValid && isMulOp &&
                          !isKilled(branchTaken, branchSqN, issueSqN);
            for (int i = 0; i < MUL_STAGES; i++) begin
                stValid[i+1] <= stValid[i] && !isKilled(branchTaken, branchSqN, stSqN[i]);
            end
            mulValid <= stValid[MUL_STAGES] &&
                        !isKilled(branchTaken, branchSqN, stSqN[MUL_STAGES]);
        end
    end

    // entry stage folds signed operands to magnitudes.
    always_ff @(posedge clk) begin
        if (issueValid) begin
            case (issueOp)
                MULH: begin
                    stInvert[0] <= issueSrcA[XLEN-1] ^ issueSrcB[XLEN-1];
                    stA[0]      <= issueSrcA[XLEN-1] ? -issueSrcA : issueSrcA;
                    stB[0]      <= issueSrcB[XLEN-1] ? -issueSrcB : issueSrcB;
                end
                MULSU: begin
                    stInvert[0] <= issueSrcA[XLEN-1];
                    stA[0]      <= issueSrcA[XLEN-1] ? -issueSrcA : issueSrcA;
                    stB[0]      <= issueSrcB;
                end
                default: begin
                    stInvert[0] <= 1'b0;       // MUL low half and MULU need no fold.
                    stA[0]      <= issueSrcA;
                    stB[0]      <= issueSrcB;
                end
            endcase
            stHigh[0] <= issueOp != MUL;
            stTag[0]  <= issueTag;
            stSqN[0]  <= issueSqN;
        end
    end

    // each stage adds one MUL_BITS slice of srcB.
    always_ff @(posedge clk) begin
        for (int i = 0; i < MUL_STAGES; i++) begin
            stInvert[i+1] <= stInvert[i];
            stHigh[i+1]   <= stHigh[i];
            stTag[i+1]    <= stTag[i];
            stSqN[i+1]    <= stSqN[i];
        end
        stAcc[1] <= PROD_W'(stA[0]) * stB[0][MUL_BITS-1:0];
        for (int i = 1; i < MUL_STAGES; i++) begin
            stA[i]     <= stA[i-1];
            stB[i]     <= stB[i-1];
            stAcc[i+1] <= stAcc[i] +
                          ((PROD_W'(stA[i]) * stB[i][MUL_BITS*i +: MUL_BITS]) << (MUL_BITS*i));
        end
    end

    always_ff @(posedge clk) begin
        mulTag <= stTag[MUL_STAGES];
        mulSqN <= stSqN[MUL_STAGES];
        if (!stHigh[MUL_STAGES]) begin
            mulResult <= stAcc[MUL_STAGES][XLEN-1:0];
        end else if (stInvert[MUL_STAGES]) begin
            mulResult <= ~stAcc[MUL_STAGES][PROD_W-1:XLEN] + {{(XLEN-1){1'b0}}, lowZero};
        end else begin
            mulResult <= stAcc[MUL_STAGES][PROD_W-1:XLEN];
        end
    end

endmodule

`default_nettype wire

//--- logic/ExecPkg.sv
`default_nettype none

package ExecPkg;

    // datapath widths.
    localparam int XLEN   = 32;
    localparam int TAG_W  = 6;
    localparam int SQN_W  = 7;              // wraps, age by signed difference.
    localparam int PROD_W = 2 * XLEN;

    // multiplier pipeline shape, MUL_STAGES may be 1, 2, 4 or 8.
    localparam int MUL_STAGES  = 2;
    localparam int MUL_BITS    = XLEN / MUL_STAGES;
    localparam int MUL_LATENCY = MUL_STAGES + 3; // entry, stages, output, bus.

    // divider iteration counter, counts 0..XLEN.
    localparam int DIV_CNT_W = $clog2(XLEN) + 1;

    typedef enum logic [2:0] {
        MUL   = 3'd0,
        MULH  = 3'd1,
        MULSU = 3'd2,
        MULU  = 3'd3,
        DIV   = 3'd4,
        DIVU  = 3'd5,
        REM   = 3'd6,
        REMU  = 3'd7
    } MulDivOp;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } DivState;

    // true when a taken branch kills a micro-op with the given sqN.
    function automatic logic isKilled(
        input logic             taken,
        input logic [SQN_W-1:0] brSqN,
        input logic [SQN_W-1:0] sqN
    );
        return taken && ($signed(sqN - brSqN) > 0);
    endfunction

endpackage

`default_nettype wire
